// ==== src.f ====
ifu_cfg_pkg.sv
mem_bus_pkg.sv
icache_data_ram.sv
fetch_pc.sv
icache.sv
inst_predecode.sv
ifu_top.sv
tb_ifu_top.sv

// ==== Bender.yml ====
package:
  name: ifu_top

sources:
  # packages first
  - ifu_cfg_pkg.sv
  - mem_bus_pkg.sv
  # design
  - icache_data_ram.sv
  - fetch_pc.sv
  - icache.sv
  - inst_predecode.sv
  - ifu_top.sv
  # testbench
  - target: test
    files:
      - tb_ifu_top.sv

// ==== tb_ifu_top.sv ====
`timescale 1ns/1ps

module tb_ifu_top;

    localparam ifu_cfg_pkg::pc_t BOOT_PC = 32'h0000_1000;
    localparam int NUM_WORDS = 300;
    // worst case near ten cycles per fetch with a four cycle memory latency
    localparam int CYCLE_LIMIT = 3000;

    localparam logic [6:0] OPC_ADDI = 7'b0010011;
    localparam logic [6:0] OPC_JAL  = 7'b1101111;
    // bne x1, x2, +8
    localparam ifu_cfg_pkg::inst_t BNE_WORD = {7'b0, 5'd2, 5'd1, 3'b001, 5'b01000, 7'b1100011};

    // planted jumps and their byte offsets
    localparam int N_JAL = 5;
    localparam ifu_cfg_pkg::pc_t JAL_AT [N_JAL] = '{
        32'h1010, 32'h121c, 32'h1400, 32'h1404, 32'h183c
    };
    localparam int JAL_OFF [N_JAL] = '{512, 484, 4, 1020, -2104};

    // planted conditional branches
    localparam int N_BR = 3;
    localparam ifu_cfg_pkg::pc_t BR_AT [N_BR] = '{32'h1008, 32'h1218, 32'h1810};

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   rd_ready;
    ifu_cfg_pkg::line_t     ret_data;
    logic                   rd_valid;
    mem_bus_pkg::mem_req_t  rw_req;
    mem_bus_pkg::mem_addr_t rd_addr;
    mem_bus_pkg::mem_size_t rd_size;
    logic                   inst_valid;
    ifu_cfg_pkg::inst_t     inst;
    ifu_cfg_pkg::pc_t       inst_pc;
    logic                   inst_is_jal;
    logic                   inst_is_branch;

    // reference state of the fetch stream
    ifu_cfg_pkg::pc_t exp_pc;
    ifu_cfg_pkg::pc_t last_pc;
    logic             have_last;
    ifu_cfg_pkg::pc_t shadow_pc;
    logic             shadow_live;

    int words_seen  = 0;
    int cycle_count = 0;
    int error_count = 0;

    ifu_top #(
        .BOOT_PC (BOOT_PC)
    ) ifu_top_i (
        .clk            (clk),
        .rst            (rst),
        .rd_ready       (rd_ready),
        .ret_data       (ret_data),
        .rd_valid       (rd_valid),
        .rw_req         (rw_req),
        .rd_addr        (rd_addr),
        .rd_size        (rd_size),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_is_jal    (inst_is_jal),
        .inst_is_branch (inst_is_branch)
    );

    always #50 clk = ~clk;

    function automatic int jal_slot(ifu_cfg_pkg::pc_t a);
        for (int i = 0; i < N_JAL; i++) begin
            if (JAL_AT[i] == a) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic is_branch_at(ifu_cfg_pkg::pc_t a);
        for (int i = 0; i < N_BR; i++) begin
            if (BR_AT[i] == a) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // J-type layout: imm[20|10:1|11|19:12], rd = x1
    function automatic ifu_cfg_pkg::inst_t encode_jal(int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic ifu_cfg_pkg::inst_t model_word(ifu_cfg_pkg::pc_t a);
        int slot;
        slot = jal_slot(a);
        if (slot >= 0) begin
            return encode_jal(JAL_OFF[slot]);
        end else if (is_branch_at(a)) begin
            return BNE_WORD;
        end
        // plain addi carrying the low address bits
        return {a[24:0], OPC_ADDI};
    endfunction

    function automatic ifu_cfg_pkg::pc_t follow_pc(ifu_cfg_pkg::pc_t a);
        int slot;
        slot = jal_slot(a);
        if (slot >= 0) begin
            return a + ifu_cfg_pkg::pc_t'(JAL_OFF[slot]);
        end
        return a + 32'd4;
    endfunction

    function automatic mem_bus_pkg::mem_addr_t line_of(ifu_cfg_pkg::pc_t a);
        return mem_bus_pkg::mem_addr_t'({a[31:3], 3'b000});
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            exp_pc      <= BOOT_PC;
            have_last   <= 1'b0;
            shadow_live <= 1'b0;
            words_seen  <= 0;
        end else if (inst_valid) begin
            exp_pc      <= follow_pc(exp_pc);
            last_pc     <= exp_pc;
            have_last   <= 1'b1;
            // a jal leaves one sequential fetch in flight that gets dropped
            shadow_live <= (jal_slot(exp_pc) >= 0);
            shadow_pc   <= exp_pc + 32'd4;
            words_seen  <= words_seen + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycle_count <= cycle_count + 1;
        end
    end

    // memory read port with random latency
    initial begin : memory_model
        int                     latency;
        mem_bus_pkg::mem_addr_t base;
        void'($urandom(34753));
        rd_ready = 1'b0;
        ret_data = '0;
        forever begin
            @(posedge clk);
            if (!rst && rd_valid === 1'b1) begin
                base    = rd_addr;
                latency = 1 + int'($urandom % 4);
                repeat (latency - 1) begin
                    @(posedge clk);
                end
                #1;
                rd_ready = 1'b1;
                ret_data = {model_word(ifu_cfg_pkg::pc_t'(base + 64'd4)),
                            model_word(ifu_cfg_pkg::pc_t'(base))};
                @(posedge clk);
                #1;
                rd_ready = 1'b0;
            end
        end
    end

    reset_quiet_a: assert property (@(posedge clk) rst |=> !inst_valid && !rd_valid)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: inst_valid or rd_valid high after reset", $time);
        end

    // pc order also covers the dropped word after a jal
    pc_order_a: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst_pc == exp_pc)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: inst_pc %h, expected %h", $time, inst_pc, exp_pc);
        end

    word_a: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> inst == model_word(exp_pc))
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: inst %h at pc %h", $time, inst, exp_pc);
        end

    class_a: assert property (@(posedge clk) disable iff (rst)
        inst_valid |-> (inst_is_jal == (jal_slot(exp_pc) >= 0))
                    && (inst_is_branch == is_branch_at(exp_pc)))
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: class jal %b branch %b at pc %h",
                     $time, inst_is_jal, inst_is_branch, exp_pc);
        end

    req_kind_a: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> rw_req == mem_bus_pkg::REQ_READ && rd_size == mem_bus_pkg::SIZE_D)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: rw_req %b rd_size %b", $time, rw_req, rd_size);
        end

    req_addr_a: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> (rd_addr == line_of(exp_pc))
                  || (shadow_live && rd_addr == line_of(shadow_pc)))
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: rd_addr %h, expected line of %h", $time, rd_addr, exp_pc);
        end

    req_hold_a: assert property (@(posedge clk) disable iff (rst)
        rd_valid && !rd_ready |=> rd_valid)
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: rd_valid dropped before rd_ready", $time);
        end

    // the line of the last delivered word is resident
    no_refetch_a: assert property (@(posedge clk) disable iff (rst)
        $rose(rd_valid) && have_last |-> rd_addr != line_of(last_pc))
        else begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: refill of resident line %h", $time, rd_addr);
        end

    initial begin : run_control
        rst = 1'b1;
        repeat (4) begin
            @(posedge clk);
        end
        #1;
        rst = 1'b0;
        while (words_seen < NUM_WORDS && cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: only %0d of %0d words delivered within %0d cycles",
                     words_seen, NUM_WORDS, CYCLE_LIMIT);
        end
        $display("run finished: %0d words, %0d cycles, %0d errors",
                 words_seen, cycle_count, error_count);
        if (error_count == 0 && words_seen >= NUM_WORDS) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== ifu_top.sv ====
`timescale 1ns/1ps

module ifu_top #(
    parameter ifu_cfg_pkg::pc_t BOOT_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_ready,
    input  ifu_cfg_pkg::line_t     ret_data,
    output logic                   rd_valid,
    output mem_bus_pkg::mem_req_t  rw_req,
    output mem_bus_pkg::mem_addr_t rd_addr,
    output mem_bus_pkg::mem_size_t rd_size,
    output logic                   inst_valid,
    output ifu_cfg_pkg::inst_t     inst,
    output ifu_cfg_pkg::pc_t       inst_pc,
    output logic                   inst_is_jal,
    output logic                   inst_is_branch
);

    // fetch to cache
    logic                       valid;
    ifu_cfg_pkg::cache_index_t  index;
    ifu_cfg_pkg::cache_tag_t    tag;
    ifu_cfg_pkg::cache_offset_t offset;
    logic                       addr_ok;
    logic                       data_ok;
    ifu_cfg_pkg::inst_t         rdata;

    // to and from pre-decode
    ifu_cfg_pkg::pc_t           word_pc;
    logic                       word_take;
    logic                       redirect;
    ifu_cfg_pkg::pc_t           redirect_pc;

    fetch_pc #(
        .BOOT_PC (BOOT_PC)
    ) fetch_pc_i (
        .clk          (clk),
        .rst          (rst),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .valid        (valid),
        .index        (index),
        .tag          (tag),
        .offset       (offset),
        .fetch_pc_out (word_pc),
        .word_take    (word_take)
    );

    icache icache_i (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .index    (index),
        .tag      (tag),
        .offset   (offset),
        .rd_ready (rd_ready),
        .ret_data (ret_data),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_valid (rd_valid),
        .rw_req   (rw_req),
        .rd_addr  (rd_addr),
        .rd_size  (rd_size)
    );

    inst_predecode inst_predecode_i (
        .clk            (clk),
        .rst            (rst),
        .word_take      (word_take),
        .word           (rdata),
        .word_pc        (word_pc),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_pc        (inst_pc),
        .inst_is_jal    (inst_is_jal),
        .inst_is_branch (inst_is_branch),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== inst_predecode.sv ====
`timescale 1ns/1ps

module inst_predecode (
    input  logic               clk,
    input  logic               rst,
    input  logic               word_take,
    input  ifu_cfg_pkg::inst_t word,
    input  ifu_cfg_pkg::pc_t   word_pc,
    output logic               inst_valid,
    output ifu_cfg_pkg::inst_t inst,
    output ifu_cfg_pkg::pc_t   inst_pc,
    output logic               inst_is_jal,
    output logic               inst_is_branch,
    output logic               redirect,
    output ifu_cfg_pkg::pc_t   redirect_pc
);

    // major opcodes
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic             is_jal;
    logic             is_branch;
    ifu_cfg_pkg::pc_t jal_imm;

    assign is_jal    = (word[6:0] == OPC_JAL);
    assign is_branch = (word[6:0] == OPC_BRANCH);

    // J-type immediate, sign extended
    assign jal_imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= word_take;
        end
    end

    always_ff @(posedge clk) begin
        if (word_take) begin
            inst           <= word;
            inst_pc        <= word_pc;
            inst_is_jal    <= is_jal;
            inst_is_branch <= is_branch;
            redirect_pc    <= word_pc + jal_imm;
        end
    end

    // one cycle pulse alongside the registered jal
    assign redirect = inst_valid & inst_is_jal;

endmodule

// ==== icache.sv ====
`timescale 1ns/1ps

module icache (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid,
    input  ifu_cfg_pkg::cache_index_t  index,
    input  ifu_cfg_pkg::cache_tag_t    tag,
    input  ifu_cfg_pkg::cache_offset_t offset,
    input  logic                       rd_ready,
    input  ifu_cfg_pkg::line_t         ret_data,
    output logic                       addr_ok,
    output logic                       data_ok,
    output ifu_cfg_pkg::inst_t         rdata,
    output logic                       rd_valid,
    output mem_bus_pkg::mem_req_t      rw_req,
    output mem_bus_pkg::mem_addr_t     rd_addr,
    output mem_bus_pkg::mem_size_t     rd_size
);

    localparam int SETS   = ifu_cfg_pkg::SETS;
    localparam int LINE_W = ifu_cfg_pkg::LINE_W;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        REPLACE
    } state_t;

    state_t state;
    state_t next_state;

    logic accept;

    // request buffer
    ifu_cfg_pkg::cache_index_t reg_index;
    ifu_cfg_pkg::cache_tag_t   reg_tag;
    logic                      reg_word_hi;

    // tag and valid tables per way
    ifu_cfg_pkg::cache_tag_t way_tag [2][SETS];
    logic [SETS-1:0]         way_valid [2];
    logic [1:0]              way_hit;
    logic                    cache_hit;

    logic                    replace_way;
    ifu_cfg_pkg::line_t      miss_buf;

    // data array port
    logic                      ram_cen;
    logic                      ram_wen;
    ifu_cfg_pkg::cache_index_t ram_addr;
    ifu_cfg_pkg::ram_row_t     ram_bwen;
    ifu_cfg_pkg::ram_row_t     ram_wdata;
    ifu_cfg_pkg::ram_row_t     ram_q;
    ifu_cfg_pkg::line_t        hit_line;

    assign accept = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_index   <= index;
            reg_tag     <= tag;
            reg_word_hi <= offset[2];
        end
    end

    // hit compare against both ways of the buffered set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = way_valid[w][reg_index] && (way_tag[w][reg_index] == reg_tag);
        end
    end

    assign cache_hit = (state == LOOKUP) && (|way_hit);

    // valid bits set by each refill
    always_ff @(posedge clk) begin
        if (rst) begin
            way_valid[0] <= '0;
            way_valid[1] <= '0;
        end else if (state == REPLACE) begin
            way_valid[replace_way][reg_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == REPLACE) begin
            way_tag[replace_way][reg_index] <= reg_tag;
        end
    end

    // victim way alternates after every refill
    always_ff @(posedge clk) begin
        if (rst) begin
            replace_way <= 1'b0;
        end else if (state == REPLACE) begin
            replace_way <= ~replace_way;
        end
    end

    // miss buffer holds the returned line until REPLACE
    always_ff @(posedge clk) begin
        if (state == MISS && rd_ready) begin
            miss_buf <= ret_data;
        end
    end

    // read on accept and write the victim half in REPLACE
    assign ram_cen   = ~(accept || (state == REPLACE));
    assign ram_wen   = ~(state == REPLACE);
    assign ram_addr  = (state == REPLACE) ? reg_index : index;
    assign ram_wdata = {miss_buf, miss_buf};
    assign ram_bwen  = replace_way ? {{LINE_W{1'b0}}, {LINE_W{1'b1}}}
                                   : {{LINE_W{1'b1}}, {LINE_W{1'b0}}};

    icache_data_ram data_ram_i (
        .clk   (clk),
        .cen   (ram_cen),
        .wen   (ram_wen),
        .bwen  (ram_bwen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .q     (ram_q)
    );

    assign hit_line = way_hit[1] ? ram_q[2*LINE_W-1:LINE_W] : ram_q[LINE_W-1:0];
    assign rdata    = reg_word_hi ? hit_line[63:32] : hit_line[31:0];

    assign addr_ok = (state == IDLE) || cache_hit;
    assign data_ok = cache_hit;

    // line refill request
    assign rd_valid = (state == MISS);
    assign rw_req   = mem_bus_pkg::REQ_READ;
    assign rd_size  = mem_bus_pkg::SIZE_D;
    assign rd_addr  = mem_bus_pkg::mem_addr_t'({reg_tag, reg_index, 3'b000});

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (valid) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    next_state = MISS;
                end else if (!valid) begin
                    next_state = IDLE;
                end
            end
            MISS: begin
                if (rd_ready) begin
                    next_state = REPLACE;
                end
            end
            REPLACE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    rd_hold_a: assert property (
        @(posedge clk) disable iff (rst) rd_valid && !rd_ready |=> rd_valid
    ) else $error("icache: rd_valid dropped before rd_ready");

    // LOOKUP is only entered with a request accepted the cycle before
    data_ok_accept_a: assert property (
        @(posedge clk) disable iff (rst) data_ok |-> $past(accept)
    ) else $error("icache: data_ok without a request accepted the cycle before");

    // a line is only refilled after missing in both ways
    one_way_hit_a: assert property (
        @(posedge clk) disable iff (rst) !(way_hit[0] && way_hit[1])
    ) else $error("icache: both ways hit set %0d", reg_index);

endmodule

// ==== fetch_pc.sv ====
`timescale 1ns/1ps

module fetch_pc #(
    parameter ifu_cfg_pkg::pc_t BOOT_PC = 32'h0000_0000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       addr_ok,
    input  logic                       data_ok,
    input  logic                       redirect,
    input  ifu_cfg_pkg::pc_t           redirect_pc,
    output logic                       valid,
    output ifu_cfg_pkg::cache_index_t  index,
    output ifu_cfg_pkg::cache_tag_t    tag,
    output ifu_cfg_pkg::cache_offset_t offset,
    output ifu_cfg_pkg::pc_t           fetch_pc_out,
    output logic                       word_take
);

    // pc of the oldest outstanding fetch
    ifu_cfg_pkg::pc_t pc_q;
    // jump target waiting for the killed fetch to drain
    ifu_cfg_pkg::pc_t target_q;
    logic             kill_q;

    logic             killing;
    ifu_cfg_pkg::pc_t target;
    ifu_cfg_pkg::pc_t next_pc;
    ifu_cfg_pkg::pc_t fetch_addr;

    // a redirect kills the fetch accepted alongside the jal
    assign killing = kill_q | redirect;
    assign target  = redirect ? redirect_pc : target_q;
    assign next_pc = killing ? target : pc_q + 32'd4;

    // present the next address as soon as the current word returns
    assign fetch_addr = data_ok ? next_pc : pc_q;

    // the fetch stream never stalls on its own side
    assign valid  = 1'b1;
    assign tag    = fetch_addr[31:9];
    assign index  = fetch_addr[8:3];
    assign offset = fetch_addr[2:0];

    assign fetch_pc_out = pc_q;
    assign word_take    = data_ok & ~killing;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q   <= BOOT_PC;
            kill_q <= 1'b0;
        end else begin
            if (valid && addr_ok) begin
                pc_q <= fetch_addr;
            end
            // cleared once the dropped word has come back
            if (data_ok && killing) begin
                kill_q <= 1'b0;
            end else if (redirect) begin
                kill_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            target_q <= redirect_pc;
        end
    end

    // jal targets and the boot address must keep fetch word aligned
    pc_aligned_a: assert property (
        @(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00
    ) else $error("fetch_pc: unaligned pc %h", pc_q);

endmodule

// ==== icache_data_ram.sv ====
`timescale 1ns/1ps

module icache_data_ram (
    input  logic                      clk,
    input  logic                      cen,
    input  logic                      wen,
    input  ifu_cfg_pkg::ram_row_t     bwen,
    input  ifu_cfg_pkg::cache_index_t addr,
    input  ifu_cfg_pkg::ram_row_t     wdata,
    output ifu_cfg_pkg::ram_row_t     q
);

    localparam int DEPTH = 2 ** $bits(ifu_cfg_pkg::cache_index_t);

    ifu_cfg_pkg::ram_row_t mem [DEPTH];

    // chip, write and bit enables are all active low
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                // masked bits keep their old value
                mem[addr] <= (mem[addr] & bwen) | (wdata & ~bwen);
            end else begin
                q <= mem[addr];
            end
        end
    end

endmodule

// ==== mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int MEM_ADDR_W = 64;

    // byte address on the memory read port
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // transfer size code
    typedef logic [1:0] mem_size_t;

    // request kind, read or write
    typedef logic mem_req_t;

    localparam mem_size_t SIZE_B = 2'b00;
    localparam mem_size_t SIZE_H = 2'b01;
    localparam mem_size_t SIZE_W = 2'b10;
    localparam mem_size_t SIZE_D = 2'b11;

    localparam mem_req_t REQ_READ  = 1'b0;
    localparam mem_req_t REQ_WRITE = 1'b1;

endpackage

// ==== ifu_cfg_pkg.sv ====
package ifu_cfg_pkg;

    // fetch datapath widths
    localparam int PC_W   = 32;
    localparam int INST_W = 32;

    // cache geometry: 2 ways, 64 sets, 8-byte lines
    localparam int WAYS       = 2;
    localparam int OFFSET_W   = 3;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = PC_W - INDEX_W - OFFSET_W;
    localparam int SETS       = 2 ** INDEX_W;
    localparam int LINE_W     = 8 * (2 ** OFFSET_W);
    localparam int RAM_ROW_W  = WAYS * LINE_W;

    // fetch address
    typedef logic [PC_W-1:0] pc_t;

    // one instruction word
    typedef logic [INST_W-1:0] inst_t;

    // pc[31:9]
    typedef logic [TAG_W-1:0] cache_tag_t;

    // pc[8:3]
    typedef logic [INDEX_W-1:0] cache_index_t;

    // pc[2:0], bit 2 picks the upper word
    typedef logic [OFFSET_W-1:0] cache_offset_t;

    // one refill line from memory
    typedef logic [LINE_W-1:0] line_t;

    // one data array row, way 0 low half, way 1 high half
    typedef logic [RAM_ROW_W-1:0] ram_row_t;

endpackage
